// ==== bench/tb_win_conf_decoder.sv ====
// self-checking testbench for the window config decoder
// config BRAM model: 8 words, one cycle read, the last word returns to zero
// every line is followed by at least one idle cycle, gaps inside a line vary
`timescale 1ns/1ps

module tb_win_conf_decoder
   import win_geom_pkg::*;
   import conf_word_pkg::*;
();

   localparam int RST_CYCLES = 8;
   localparam int CONF_LINES = 8;
   localparam int REPEATS    = 2;   // second pass runs after the return

   logic                   clk;
   logic                   rst_n;
   logic                   pix_vld;
   logic [PIX_W-1:0]       pix_data;
   logic [CONF_W-1:0]      conf_rd_data = '0;
   logic [CONF_ADDR_W-1:0] conf_rd_addr;
   logic [OUT_W-1:0]       wr_data;
   logic [MASK_W-1:0]      wr_mask;
   logic [GROUPS-1:0]      wr_group_en;
   logic [INC_W-1:0]       wr_addr_inc;

   logic [CONF_W-1:0]      conf_mem [0:CONF_LINES-1];
   logic [CONF_ADDR_W-1:0] model_addr = '0;   // follows conf_rd_addr one cycle early
   int                     model_grp  = 0;
   integer                 seed       = 94217;
   int                     gap_q [$];          // idle cycles, in order of use
   int                     cycle_cnt  = 0;
   int                     cycle_limit = 1000000;
   int                     data_errs  = 0;
   int                     lat_errs   = 0;
   int                     addr_errs  = 0;

   // expected writes, oldest first
   logic [OUT_W-1:0]  exp_data_q [$];
   logic [MASK_W-1:0] exp_mask_q [$];
   logic [GROUPS-1:0] exp_en_q [$];
   logic [INC_W-1:0]  exp_inc_q [$];
   logic [OUT_W-1:0]  exp_data;
   logic [MASK_W-1:0] exp_mask;
   logic [GROUPS-1:0] exp_en;
   logic [INC_W-1:0]  exp_inc;
   logic              have_exp = 1'b0;

   win_conf_decoder dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) conf_rd_data <= conf_mem[conf_rd_addr[2:0]];   // BRAM read

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout: run still busy after %0d cycles", cycle_cnt);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // reference model
   function automatic logic [CONF_W-1:0] make_conf(input int off, input logic [2:0] order,
                                                   input int cycle, input logic ret);
      logic [CONF_W-1:0] w;
      w = '0;
      w[OFFSET_LSB +: OFFSET_W] = OFFSET_W'(off);
      w[ORDER_LSB +: ORDER_W]   = order;
      w[CYCLE_LSB +: CYCLE_W]   = CYCLE_W'(cycle);
      w[RET_BIT]                = ret;
      return w;
   endfunction

   task automatic push_expected(input logic [PIX_W-1:0] d, input int off,
                                input logic [LANES-1:0] flag, input int grp);
      logic [GROUP_W-1:0]     placed;
      logic [GROUP_BYTES-1:0] pmask;
      logic [OUT_W-1:0]       data;
      logic [MASK_W-1:0]      mask;
      int                     k;
      int                     dst;
      placed = '0;
      pmask  = '0;
      data   = '0;
      mask   = '0;
      for (int b = 0; b < PIX_BYTES; b++) begin
         placed[(b + off)*BYTE_W +: BYTE_W] = d[b*BYTE_W +: BYTE_W];
         pmask[b + off] = 1'b1;
      end
      case (flag)
         3'b010:  k = 1;
         3'b100:  k = 2;
         default: k = 0;   // 001 or not one-hot
      endcase
      // byte of lane j lands in lane (j+k) mod 3 of the selected group
      for (int bi = 0; bi < GROUP_BYTES; bi++) begin
         dst = ((bi / LANE_BYTES + k) % LANES) * LANE_BYTES + bi % LANE_BYTES;
         data[grp*GROUP_W + dst*BYTE_W +: BYTE_W] = placed[bi*BYTE_W +: BYTE_W];
         mask[grp*GROUP_BYTES + dst] = pmask[bi];
      end
      exp_data_q.push_back(data);
      exp_mask_q.push_back(mask);
      exp_en_q.push_back(GROUPS'(1) << grp);
      exp_inc_q.push_back(INC_W'(flag) << (grp * LANES));
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         pix_vld <= 1'b0;
      end
   endtask

   task automatic drive_beat(input int off, input logic [LANES-1:0] flag, input int grp);
      logic [PIX_W-1:0] d;
      d = {$random(seed), $random(seed), $random(seed), $random(seed)};
      @(posedge clk);
      pix_vld  <= 1'b1;
      pix_data <= d;
      push_expected(d, off, flag, grp);
   endtask

   task automatic send_line();
      logic [CONF_W-1:0] word;
      logic [LANES-1:0]  flag;
      int                off;
      int                n_beats;
      word    = conf_mem[model_addr[2:0]];
      off     = int'(word[OFFSET_LSB +: OFFSET_W]);
      n_beats = int'(word[CYCLE_LSB +: CYCLE_W]) + 1;
      flag    = word[ORDER_LSB +: ORDER_W];
      for (int j = 0; j < n_beats; j++) begin
         if (j > 0) begin
            idle(gap_q.pop_front());
            flag = {flag[0], flag[2:1]};   // rotate right, bit 0 to bit 2
         end
         drive_beat(off, flag, model_grp);
      end
      model_addr <= word[RET_BIT] ? '0 : model_addr + 1'b1;
      model_grp = (model_grp + 1) % GROUPS;
      idle(gap_q.pop_front());
   endtask

   initial begin
      int total;
      int nb;
      int g;
      rst_n    = 1'b0;
      pix_vld  = 1'b0;
      pix_data = '0;
      conf_mem[0] = make_conf(0, 3'b001, 2, 1'b0);
      conf_mem[1] = make_conf(1, 3'b010, 0, 1'b0);
      conf_mem[2] = make_conf(2, 3'b100, 3, 1'b0);
      conf_mem[3] = make_conf(3, 3'b011, 1, 1'b0);   // no rotation
      conf_mem[4] = make_conf(4, 3'b001, 4, 1'b0);
      conf_mem[5] = make_conf(5, 3'b010, 0, 1'b0);
      conf_mem[5][CONF_W-1:RET_BIT+1] = 4'b1010;     // undecoded bits
      conf_mem[6] = make_conf(6, 3'b100, 2, 1'b0);
      conf_mem[7] = make_conf(7, 3'b110, 1, 1'b1);
      // draw every gap up front so the run length is known
      total = 0;
      for (int r = 0; r < REPEATS; r++) begin
         for (int ln = 0; ln < CONF_LINES; ln++) begin
            nb = int'(conf_mem[ln][CYCLE_LSB +: CYCLE_W]) + 1;
            for (int j = 1; j < nb; j++) begin
               g = {$random(seed)} % 3;
               gap_q.push_back(g);
               total += g;
            end
            g = 1 + {$random(seed)} % 3;
            gap_q.push_back(g);
            total += nb + g;
         end
      end
      cycle_limit = 2 * (RST_CYCLES + total + ALIGN_LAT + 2) + 50;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      idle(4);
      for (int n = 0; n < REPEATS * CONF_LINES; n++) send_line();
      while (exp_data_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      $display("errors: %0d data, %0d latency, %0d address", data_errs, lat_errs, addr_errs);
      if (data_errs + lat_errs + addr_errs == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // ------------------------------------------------------------------------
   // checks, the head of the queue is taken while the outputs are stable
   always @(negedge clk) begin
      if (rst_n && wr_group_en != '0) begin
         have_exp = exp_data_q.size() != 0;
         if (have_exp) begin
            exp_data = exp_data_q.pop_front();
            exp_mask = exp_mask_q.pop_front();
            exp_en   = exp_en_q.pop_front();
            exp_inc  = exp_inc_q.pop_front();
         end
      end
   end

   check_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_group_en != '0) |-> have_exp)
      else begin
         data_errs++;
         $display("a write appeared at %0t with no beat left to match it", $time);
      end

   check_write: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_group_en != '0 && have_exp) |-> (wr_data == exp_data && wr_mask == exp_mask
                                           && wr_group_en == exp_en && wr_addr_inc == exp_inc))
      else begin
         data_errs++;
         $display("[FAIL] %0t: write differs, en %b inc %b, expected en %b inc %b",
                  $time, wr_group_en, wr_addr_inc, exp_en, exp_inc);
      end

   check_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_group_en == '0) |-> (wr_addr_inc == '0 && wr_mask == '0))
      else begin
         data_errs++;
         $display("[FAIL] %0t: increments or mask nonzero with no group enabled", $time);
      end

   check_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_group_en != '0) == $past(pix_vld, ALIGN_LAT))
      else begin
         lat_errs++;
         $display("[FAIL] %0t: write enable not %0d cycles after a beat", $time, ALIGN_LAT);
      end

   check_addr: assert property (@(posedge clk) disable iff (!rst_n)
      conf_rd_addr == $past(model_addr))
      else begin
         addr_errs++;
         $display("[FAIL] %0t: conf_rd_addr is %0d", $time, conf_rd_addr);
      end

endmodule

// ==== files.f ====
hw/win_geom_pkg.sv
hw/conf_word_pkg.sv
hw/line_seq.sv
hw/pixel_align.sv
hw/group_router.sv
hw/win_conf_decoder.sv
bench/tb_win_conf_decoder.sv

// ==== hw/conf_word_pkg.sv ====
// layout of one configuration BRAM word, one word per line
// bits 18..15 are not decoded
package conf_word_pkg;

   localparam int CONF_W      = 19;
   localparam int CONF_ADDR_W = 9;

   // byte offset of the beat inside the group word
   localparam int OFFSET_LSB = 0;
   localparam int OFFSET_W   = 3;

   // initial shuffle flag of the line
   localparam int ORDER_LSB = 3;
   localparam int ORDER_W   = 3;

   // beats in the line minus one
   localparam int CYCLE_LSB = 6;
   localparam int CYCLE_W   = 8;

   localparam int RET_BIT = 14;   // return to address zero after this line

endpackage

// ==== hw/group_router.sv ====
// routes the aligned word to the active group's slice of the write port
// all slices other than the enabled group are driven to zero
`timescale 1ns/1ps

module group_router
   import win_geom_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   aligned_vld,
   input  logic [GROUP_W-1:0]     aligned_data,
   input  logic [GROUP_BYTES-1:0] aligned_mask,
   input  logic [LANES-1:0]       aligned_flag,
   input  logic [GROUPS-1:0]      group_sel,
   output logic [OUT_W-1:0]       wr_data,
   output logic [MASK_W-1:0]      wr_mask,
   output logic [GROUPS-1:0]      wr_group_en,
   output logic [INC_W-1:0]       wr_addr_inc
);

   // group_sel as seen in the beat cycle, two cycles on
   logic [GROUPS-1:0] gsel_d1;
   logic [GROUPS-1:0] gsel_d2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gsel_d1 <= GROUPS'(1);
         gsel_d2 <= GROUPS'(1);
      end else begin
         gsel_d1 <= group_sel;
         gsel_d2 <= gsel_d1;
      end
   end

   // ------------------------------------------------------------------------
   // write enables and address increments
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_group_en <= '0;
         wr_addr_inc <= '0;
      end else begin
         wr_group_en <= aligned_vld ? gsel_d2 : '0;
         for (int g = 0; g < GROUPS; g++) begin
            if (aligned_vld && gsel_d2[g]) begin
               wr_addr_inc[g*LANES +: LANES] <= aligned_flag;
            end else begin
               wr_addr_inc[g*LANES +: LANES] <= '0;
            end
         end
      end
   end

   // data and mask slices
   always_ff @(posedge clk) begin
      for (int g = 0; g < GROUPS; g++) begin
         if (aligned_vld && gsel_d2[g]) begin
            wr_data[g*GROUP_W +: GROUP_W]         <= aligned_data;
            wr_mask[g*GROUP_BYTES +: GROUP_BYTES] <= aligned_mask;
         end else begin
            wr_data[g*GROUP_W +: GROUP_W]         <= '0;
            wr_mask[g*GROUP_BYTES +: GROUP_BYTES] <= '0;
         end
      end
   end

endmodule

// ==== hw/line_seq.sv ====
// line sequencing: beat counter, config address and active group
// the config address moves on a line's last beat, so the next line's first
// beat needs at least one idle cycle before it (one-cycle BRAM read)
`timescale 1ns/1ps

module line_seq
   import win_geom_pkg::*;
   import conf_word_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pix_vld,
   input  logic [CONF_W-1:0]      conf_rd_data,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output logic                   line_first,
   output logic [GROUPS-1:0]      group_sel
);

   logic [CYCLE_W-1:0] beat_cnt;     // beats still to come in this line
   logic               ret_flag;
   logic [CYCLE_W-1:0] conf_cycle;
   logic               conf_ret;
   logic               line_last;
   logic               ret_now;

   // ------------------------------------------------------------------------
   // config word fields
   assign conf_cycle = conf_rd_data[CYCLE_LSB +: CYCLE_W];
   assign conf_ret   = conf_rd_data[RET_BIT];

   assign line_first = pix_vld && (beat_cnt == '0);

   // single-beat line ends on its first beat
   assign line_last = line_first ? (conf_cycle == '0)
                                 : (pix_vld && (beat_cnt == CYCLE_W'(1)));

   assign ret_now = line_first ? conf_ret : ret_flag;   // flag not latched yet

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_cnt <= '0;
         ret_flag <= 1'b0;
      end else if (pix_vld) begin
         if (line_first) begin
            beat_cnt <= conf_cycle;
            ret_flag <= conf_ret;
         end else begin
            beat_cnt <= beat_cnt - 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // line end: next config word, next group
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         conf_rd_addr <= '0;
         group_sel    <= GROUPS'(1);
      end else if (line_last) begin
         if (ret_now) begin
            conf_rd_addr <= '0;
         end else begin
            conf_rd_addr <= conf_rd_addr + 1'b1;
         end
         group_sel <= {group_sel[GROUPS-2:0], group_sel[GROUPS-1]};   // 2 wraps to 0
      end
   end

endmodule

// ==== hw/pixel_align.sv ====
// two-stage alignment of an input beat into a 24-byte group word
// stage 1 places the beat at the byte offset, stage 2 rotates the lanes
// the config word must stay stable for the whole line
`timescale 1ns/1ps

module pixel_align
   import win_geom_pkg::*;
   import conf_word_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pix_vld,
   input  logic [PIX_W-1:0]       pix_data,
   input  logic [CONF_W-1:0]      conf_rd_data,
   input  logic                   line_first,
   output logic                   aligned_vld,
   output logic [GROUP_W-1:0]     aligned_data,
   output logic [GROUP_BYTES-1:0] aligned_mask,
   output logic [LANES-1:0]       aligned_flag
);

   logic [OFFSET_W-1:0]    conf_offset;
   logic [ORDER_W-1:0]     conf_order;
   logic [LANES-1:0]       flag_next;
   logic [LANES-1:0]       shuf_flag;      // flag of the beat in stage 1
   logic                   s1_vld;
   logic [GROUP_W-1:0]     s1_data;
   logic [GROUP_BYTES-1:0] s1_mask;
   logic [1:0]             rot_k;
   logic [GROUP_W-1:0]     rot_data;
   logic [GROUP_BYTES-1:0] rot_mask;

   assign conf_offset = conf_rd_data[OFFSET_LSB +: OFFSET_W];
   assign conf_order  = conf_rd_data[ORDER_LSB +: ORDER_W];

   // order field starts the line, then rotate right each beat
   assign flag_next = line_first ? conf_order : {shuf_flag[0], shuf_flag[LANES-1:1]};

   // ------------------------------------------------------------------------
   // stage 1: placement and mask
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_vld    <= 1'b0;
         shuf_flag <= '0;
      end else begin
         s1_vld <= pix_vld;
         if (pix_vld) begin
            shuf_flag <= flag_next;
         end
      end
   end

   always_ff @(posedge clk) begin
      s1_data <= GROUP_W'(pix_data) << (BYTE_W * conf_offset);
      s1_mask <= GROUP_BYTES'({PIX_BYTES{1'b1}}) << conf_offset;
   end

   // ------------------------------------------------------------------------
   // stage 2: lane rotation, out lane i <= in lane (i-k) mod 3
   always_comb begin
      case (shuf_flag)
         3'b010:  rot_k = 2'd1;
         3'b100:  rot_k = 2'd2;
         default: rot_k = 2'd0;   // 001 and non-one-hot flags
      endcase
   end

   always_comb begin
      int src;
      for (int i = 0; i < LANES; i++) begin
         src = (i + LANES - int'(rot_k)) % LANES;
         rot_data[i*LANE_BYTES*BYTE_W +: LANE_BYTES*BYTE_W] =
            s1_data[src*LANE_BYTES*BYTE_W +: LANE_BYTES*BYTE_W];
         rot_mask[i*LANE_BYTES +: LANE_BYTES] = s1_mask[src*LANE_BYTES +: LANE_BYTES];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aligned_vld <= 1'b0;
      end else begin
         aligned_vld <= s1_vld;
      end
   end

   always_ff @(posedge clk) begin
      aligned_data <= rot_data;
      aligned_mask <= rot_mask;
      aligned_flag <= shuf_flag;   // doubles as per-lane address increment
   end

endmodule

// ==== hw/win_conf_decoder.sv ====
// window buffer config decoder, beat to write port latency is 3 cycles
// no back-pressure, every beat is written; leave one idle cycle after a
// line's last beat so the next config word can be read
`timescale 1ns/1ps

module win_conf_decoder
   import win_geom_pkg::*;
   import conf_word_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pix_vld,
   input  logic [PIX_W-1:0]       pix_data,
   input  logic [CONF_W-1:0]      conf_rd_data,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output logic [OUT_W-1:0]       wr_data,
   output logic [MASK_W-1:0]      wr_mask,
   output logic [GROUPS-1:0]      wr_group_en,
   output logic [INC_W-1:0]       wr_addr_inc
);

   logic                   line_first;
   logic [GROUPS-1:0]      group_sel;
   logic                   aligned_vld;
   logic [GROUP_W-1:0]     aligned_data;
   logic [GROUP_BYTES-1:0] aligned_mask;
   logic [LANES-1:0]       aligned_flag;

   line_seq u_line_seq (
      .clk          (clk),
      .rst_n        (rst_n),
      .pix_vld      (pix_vld),
      .conf_rd_data (conf_rd_data),
      .conf_rd_addr (conf_rd_addr),
      .line_first   (line_first),
      .group_sel    (group_sel)
   );

   pixel_align u_pixel_align (
      .clk (clk), .rst_n (rst_n), .pix_vld (pix_vld), .pix_data (pix_data),
      .conf_rd_data (conf_rd_data), .line_first (line_first),
      .aligned_vld (aligned_vld), .aligned_data (aligned_data),
      .aligned_mask (aligned_mask), .aligned_flag (aligned_flag)
   );

   group_router u_group_router (
      .clk (clk), .rst_n (rst_n), .aligned_vld (aligned_vld),
      .aligned_data (aligned_data), .aligned_mask (aligned_mask),
      .aligned_flag (aligned_flag), .group_sel (group_sel),
      .wr_data (wr_data), .wr_mask (wr_mask),
      .wr_group_en (wr_group_en), .wr_addr_inc (wr_addr_inc)
   );

endmodule

// ==== hw/win_geom_pkg.sv ====
// geometry of the sliding-window buffer: three groups of three 8-byte BRAMs
// one input beat carries 16 pixels of 8 bits
package win_geom_pkg;

   localparam int BYTE_W     = 8;    // bits per pixel
   localparam int PIX_BYTES  = 16;   // pixels per input beat
   localparam int LANE_BYTES = 8;    // bytes per BRAM word
   localparam int LANES      = 3;    // BRAMs per group
   localparam int GROUPS     = 3;

   localparam int GROUP_BYTES = LANES * LANE_BYTES;         // 24
   localparam int PIX_W       = PIX_BYTES * BYTE_W;         // 128
   localparam int GROUP_W     = GROUP_BYTES * BYTE_W;       // 192

   // flattened write port, group 0 in the low bits
   localparam int OUT_W  = GROUPS * GROUP_W;                // 576
   localparam int MASK_W = GROUPS * GROUP_BYTES;            // 72
   localparam int INC_W  = GROUPS * LANES;                  // 9

   // beat in cycle T shows up on the write port in T+3
   localparam int ALIGN_LAT = 3;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_win_conf_decoder
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" -Mdir "$OBJ" -o "$TOP" -f files.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qF '** FAIL **' "$LOG"; then
   echo "simulation reported a failure, see $LOG"
   exit 1
fi
if ! grep -qF '** PASS **' "$LOG"; then
   echo "simulation ended without a result, see $LOG"
   exit 1
fi
echo "simulation passed"
exit 0
